//--- Bender.yml
package:
  name: tile_raster

sources:
  - common/raster_pkg.sv
  - common/slice_in_if.sv
  - common/quad_out_if.sv
  - logic/edge_setup.sv
  - raster_slice/raster_slice.sv
  - logic/quad_merge.sv
  - logic/tile_raster.sv
  - target: simulation
    files:
      - dv/tile_raster_tb.sv

//--- common/quad_out_if.sv
//////////////////////////////////////////////////
// one quad per valid strobe, no back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface quad_out_if;

    logic                     valid;
    raster_pkg::raster_quad_t quad;
    logic                     busy;   // slice is walking a tile

    modport slice (
        output valid,
        output quad,
        output busy
    );

    modport merge (
        input valid,
        input quad,
        input busy
    );

endinterface

//--- common/raster_pkg.sv
//////////////////////////////////////////////////
// tile geometry is fixed at 8x8 pixels in 2x2 quads
// slice count and output lanes must stay equal
//////////////////////////////////////////////////

package raster_pkg;

    //////////////////////////////////////////////////
    // widths

    localparam int DIM_BITS  = 12;  // tile and pixel coordinates
    localparam int PID_BITS  = 8;
    localparam int EDGE_BITS = 32;  // signed edge values

    //////////////////////////////////////////////////
    // tile geometry and parallelism

    localparam int TILE_LOGSIZE   = 3;
    localparam int QUADS_PER_TILE = 16;
    localparam int QUAD_IDX_BITS  = 4;

    localparam int NUM_SLICES    = 4;
    localparam int SLICE_BITS    = 2;
    localparam int OUT_LANES     = 4;
    localparam int LANE_CNT_BITS = 3;  // counts 0 to OUT_LANES

    // edge function e(x, y) = a*x + b*y + c
    typedef struct packed {
        logic signed [EDGE_BITS-1:0] a;
        logic signed [EDGE_BITS-1:0] b;
        logic signed [EDGE_BITS-1:0] c;
    } edge_t;

    // one 2x2 quad, pos is the top left pixel
    typedef struct packed {
        logic [DIM_BITS-1:0] pos_x;
        logic [DIM_BITS-1:0] pos_y;
        logic [3:0]          mask;   // bit 0 top left, bit 3 bottom right
        logic [PID_BITS-1:0] pid;
    } raster_quad_t;

endpackage

//--- common/slice_in_if.sv
//////////////////////////////////////////////////
// one primitive per start strobe, no ready
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface slice_in_if;

    logic                            start;
    logic [raster_pkg::DIM_BITS-1:0] org_x;   // pixel origin of tile
    logic [raster_pkg::DIM_BITS-1:0] org_y;
    logic [raster_pkg::PID_BITS-1:0] pid;
    raster_pkg::edge_t [2:0]         edges;   // c holds value at origin

    modport setup (
        output start,
        output org_x,
        output org_y,
        output pid,
        output edges
    );

    modport slice (
        input start,
        input org_x,
        input org_y,
        input pid,
        input edges
    );

endinterface

//--- dv/tile_raster_stim.txt
# gap tile_x tile_y pid  a0 b0 c0  a1 b1 c1  a2 b2 c2  coverage
# gap in idle cycles, coefficients in decimal, coverage in hex with bit ly*8+lx
# burst 1: full tile, half planes, small triangle, diagonal
4  0   0  1   0  0    1    0  0    1    0  0    1   FFFFFFFFFFFFFFFF
4  2   1  2   1  0  -20    0  0    0    0  0    0   F0F0F0F0F0F0F0F0
5  0   3  3   0 -1   26    0  0    0    0  0    0   0000000000FFFFFF
4  1   1  4  -1 -1   23    1 -1    0    0  1   -9   00000000183C7E00
6  3   0  5   1 -1  -24    0  0    0    0  0    0   80C0E0F0F8FCFEFF
# burst 2: fully culled, still drains to done
30 7   7  6   0  0   -1    0  0    1    0  0    1   0000000000000000
# burst 3: corners, thin column, steep edge, far tile
30 5   7  7  -1  0   41    0  1  -62    0  0    5   0303000000000000
4  6   2  8   1  0  -51   -1  0   51    0  1  -21   0808080000000000
7  100 50 9   2 -1 -1200   0  0    0    0  0    0   F0F8F8FCFCFEFEFF
5  9   3  10  1  0  -74    0  1  -26   -1 -1  104   00040C1C3C7C0000

//--- dv/tile_raster_tb.sv
//////////////////////////////////////////////////
// primitives and expected maps come from the stim file
// pids in the file must be unique, gaps at least 4
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tile_raster_tb;

    localparam int MAX_PRIMS = 32;
    localparam int NUM_PIDS  = 256;
    localparam int TILE_SIDE = 1 << raster_pkg::TILE_LOGSIZE;

    logic                                                 clk   = 1'b0;
    logic                                                 reset = 1'b1;
    logic                                                 prim_valid;
    logic [raster_pkg::DIM_BITS-1:0]                      prim_tile_x;
    logic [raster_pkg::DIM_BITS-1:0]                      prim_tile_y;
    logic [raster_pkg::PID_BITS-1:0]                      prim_pid;
    raster_pkg::edge_t [2:0]                              prim_edges;
    logic                                                 quad_valid;
    logic [raster_pkg::LANE_CNT_BITS-1:0]                 quad_count;
    raster_pkg::raster_quad_t [raster_pkg::OUT_LANES-1:0] quad_lanes;
    logic                                                 done;

    // stim file contents, gaps after randomizing
    int          num_prims;
    int          stim_gap  [MAX_PRIMS];
    int          stim_tx   [MAX_PRIMS];
    int          stim_ty   [MAX_PRIMS];
    int          stim_pid  [MAX_PRIMS];
    int          stim_coef [MAX_PRIMS][9];
    logic [63:0] stim_map  [MAX_PRIMS];

    //////////////////////////////////////////////////
    // scoreboard per pid

    int          strobe_t [NUM_PIDS];  // -1 until strobed
    int          org_x    [NUM_PIDS];
    int          org_y    [NUM_PIDS];
    logic [63:0] cov_map  [NUM_PIDS];  // bit ly*8+lx

    int cycle      = 0;
    int last_t     = 0;
    int done_count = 0;
    int done_mark  = 0;
    int wd_cycles  = 0;

    tile_raster tile_raster_i (
        .clk         (clk),
        .reset       (reset),
        .prim_valid  (prim_valid),
        .prim_tile_x (prim_tile_x),
        .prim_tile_y (prim_tile_y),
        .prim_pid    (prim_pid),
        .prim_edges  (prim_edges),
        .quad_valid  (quad_valid),
        .quad_count  (quad_count),
        .quad_lanes  (quad_lanes),
        .done        (done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift_next(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic read_stim();
        int          fd;
        int          n;
        int          line_no;
        int          g;
        int          tx;
        int          ty;
        int          pid;
        int          coef [9];
        logic [63:0] map;
        string       line;
        fd = $fopen("dv/tile_raster_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open dv/tile_raster_stim.txt");
        end
        num_prims = 0;
        line_no   = 0;
        while ($fgets(line, fd) > 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %h", g, tx, ty, pid,
                        coef[0], coef[1], coef[2], coef[3], coef[4], coef[5],
                        coef[6], coef[7], coef[8], map);
            assert (n == 14 && g >= 4 && num_prims < MAX_PRIMS) else
                abort_run($sformatf("stim line %0d is malformed or its gap is below 4", line_no));
            stim_gap[num_prims] = g;
            stim_tx[num_prims]  = tx;
            stim_ty[num_prims]  = ty;
            stim_pid[num_prims] = pid;
            stim_map[num_prims] = map;
            for (int c = 0; c < 9; c++) begin
                stim_coef[num_prims][c] = coef[c];
            end
            num_prims++;
        end
        $fclose(fd);
    endtask

    // position, timing and overlap of one output quad
    task automatic check_quad(input raster_pkg::raster_quad_t q, input int m);
        int dx;
        int dy;
        int k;
        int bit_idx;
        assert (strobe_t[q.pid] >= 0) else
            abort_run($sformatf("** Error @ %0t: quad for unknown pid %0d", $time, q.pid));
        dx = int'(q.pos_x) - org_x[q.pid];
        dy = int'(q.pos_y) - org_y[q.pid];
        assert (dx >= 0 && dx < TILE_SIDE && dy >= 0 && dy < TILE_SIDE
                && dx % 2 == 0 && dy % 2 == 0 && q.mask != 4'b0000) else
            abort_run($sformatf("** Error @ %0t: pid %0d quad at (%0d,%0d) mask %b", $time,
                                q.pid, q.pos_x, q.pos_y, q.mask));
        k = (dy / 2) * (TILE_SIDE / 2) + dx / 2;  // row-major quad index
        assert (m == strobe_t[q.pid] + 3 + k) else
            abort_run($sformatf("** Error @ %0t: pid %0d quad %0d at cycle %0d, expected %0d",
                                $time, q.pid, k, m, strobe_t[q.pid] + 3 + k));
        for (int p = 0; p < 4; p++) begin
            if (q.mask[p]) begin
                bit_idx = (dy + p / 2) * TILE_SIDE + dx + p % 2;
                assert (!cov_map[q.pid][bit_idx]) else
                    abort_run($sformatf("** Error @ %0t: pid %0d pixel %0d covered twice",
                                        $time, q.pid, bit_idx));
                cov_map[q.pid][bit_idx] = 1'b1;
            end
        end
    endtask

    task automatic drive_prim(input int i);
        raster_pkg::edge_t [2:0] ev;
        int                      exp_done;
        repeat (stim_gap[i]) @(posedge clk);
        for (int e = 0; e < 3; e++) begin
            ev[e].a = stim_coef[i][3*e];
            ev[e].b = stim_coef[i][3*e+1];
            ev[e].c = stim_coef[i][3*e+2];
        end
        // bursts overlap below 15 idle cycles, drain fully from 20 on
        if (i == 0 || stim_gap[i] < 15) begin
            exp_done = 0;
        end else if (stim_gap[i] >= 20) begin
            exp_done = 1;
        end else begin
            exp_done = -1;
        end
        if (exp_done >= 0) begin
            assert (done_count - done_mark == exp_done) else
                abort_run($sformatf("** Error @ %0t: %0d done pulses before pid %0d, expected %0d",
                                    $time, done_count - done_mark, stim_pid[i], exp_done));
        end
        done_mark = done_count;
        strobe_t[stim_pid[i]] = cycle + 1;  // edge where setup registers it
        org_x[stim_pid[i]]    = stim_tx[i] * TILE_SIDE;
        org_y[stim_pid[i]]    = stim_ty[i] * TILE_SIDE;
        last_t      <= cycle + 1;
        prim_valid  <= 1'b1;
        prim_tile_x <= raster_pkg::DIM_BITS'(stim_tx[i]);
        prim_tile_y <= raster_pkg::DIM_BITS'(stim_ty[i]);
        prim_pid    <= raster_pkg::PID_BITS'(stim_pid[i]);
        prim_edges  <= ev;
        @(posedge clk);
        prim_valid  <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // output monitor

    always @(posedge clk) begin : monitor
        raster_pkg::raster_quad_t q;
        if (!reset) begin
            if (done) begin
                done_count <= done_count + 1;
                assert (!quad_valid && cycle >= last_t + 18) else
                    abort_run($sformatf("** Error @ %0t: done at cycle %0d, last strobe %0d",
                                        $time, cycle, last_t));
            end
            assert (quad_valid == (quad_count != 0) && quad_count <= raster_pkg::OUT_LANES) else
                abort_run($sformatf("** Error @ %0t: quad_valid %0b with quad_count %0d",
                                    $time, quad_valid, quad_count));
            for (int l = 0; l < raster_pkg::OUT_LANES; l++) begin
                q = quad_lanes[l];
                if (l < quad_count) begin
                    check_quad(q, cycle);
                end else begin
                    assert (q == '0) else
                        abort_run($sformatf("** Error @ %0t: lane %0d above count %0d not zero",
                                            $time, l, quad_count));
                end
            end
        end
    end

    initial begin : watchdog
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        abort_run($sformatf("timeout, the run did not finish within %0d cycles", wd_cycles));
    end

    initial begin : driver
        logic [31:0] rng;
        int          wd;
        int          mark;
        prim_valid  = 1'b0;
        prim_tile_x = '0;
        prim_tile_y = '0;
        prim_pid    = '0;
        prim_edges  = '0;
        for (int p = 0; p < NUM_PIDS; p++) begin
            strobe_t[p] = -1;
            org_x[p]    = 0;
            org_y[p]    = 0;
            cov_map[p]  = '0;
        end
        read_stim();
        assert (num_prims > 0) else abort_run("the stim file holds no primitives");
        rng = 32'h5c136912;
        wd  = 10;
        for (int i = 0; i < num_prims; i++) begin
            rng = xorshift_next(rng);
            stim_gap[i] = stim_gap[i] + int'(rng[1:0]);  // stretch only
            wd = wd + stim_gap[i] + 40;
        end
        wd_cycles = wd;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < num_prims; i++) begin
            drive_prim(i);
        end

        // final drain, exactly one done
        mark = done_count;
        while (done_count == mark) begin
            @(posedge clk);
        end
        repeat (25) @(posedge clk);
        assert (done_count == mark + 1) else
            abort_run($sformatf("** Error @ %0t: %0d done pulses after last burst, expected 1",
                                $time, done_count - mark));
        for (int i = 0; i < num_prims; i++) begin
            assert (cov_map[stim_pid[i]] == stim_map[i]) else
                abort_run($sformatf("** Error @ %0t: pid %0d coverage %h, expected %h", $time,
                                    stim_pid[i], cov_map[stim_pid[i]], stim_map[i]));
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- logic/edge_setup.sv
//////////////////////////////////////////////////
// strobes must be at least NUM_SLICES cycles apart
// edge products wrap to EDGE_BITS
//////////////////////////////////////////////////

`timescale 1ns/1ps

module edge_setup (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                prim_valid,
    input  logic [raster_pkg::DIM_BITS-1:0]     prim_tile_x,
    input  logic [raster_pkg::DIM_BITS-1:0]     prim_tile_y,
    input  logic [raster_pkg::PID_BITS-1:0]     prim_pid,
    input  raster_pkg::edge_t [2:0]             prim_edges,
    slice_in_if.setup                           slices [raster_pkg::NUM_SLICES]
);

    logic [raster_pkg::DIM_BITS-1:0]   org_x;
    logic [raster_pkg::DIM_BITS-1:0]   org_y;
    raster_pkg::edge_t [2:0]           edges_eval;

    logic [raster_pkg::NUM_SLICES-1:0] start_q;
    logic [raster_pkg::SLICE_BITS-1:0] rr_ptr;
    logic [raster_pkg::DIM_BITS-1:0]   org_x_q;
    logic [raster_pkg::DIM_BITS-1:0]   org_y_q;
    logic [raster_pkg::PID_BITS-1:0]   pid_q;
    raster_pkg::edge_t [2:0]           edges_q;

    // tile index to pixel origin
    assign org_x = prim_tile_x << raster_pkg::TILE_LOGSIZE;
    assign org_y = prim_tile_y << raster_pkg::TILE_LOGSIZE;

    //////////////////////////////////////////////////
    // edge value at tile origin

    always_comb begin
        for (int e = 0; e < 3; e++) begin
            edges_eval[e]   = prim_edges[e];
            edges_eval[e].c = prim_edges[e].a * $signed({1'b0, org_x})
                            + prim_edges[e].b * $signed({1'b0, org_y})
                            + prim_edges[e].c;
        end
    end

    //////////////////////////////////////////////////
    // round-robin dispatch

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q <= '0;
            rr_ptr  <= '0;
        end else begin
            start_q <= prim_valid ? (raster_pkg::NUM_SLICES'(1) << rr_ptr) : '0;
            if (prim_valid) begin
                rr_ptr <= rr_ptr + 1'b1;  // wraps at NUM_SLICES
            end
        end
    end

    // shared payload, only the started slice latches it
    always_ff @(posedge clk) begin
        if (prim_valid) begin
            org_x_q <= org_x;
            org_y_q <= org_y;
            pid_q   <= prim_pid;
            edges_q <= edges_eval;
        end
    end

    for (genvar i = 0; i < raster_pkg::NUM_SLICES; i++) begin : g_slice
        assign slices[i].start = start_q[i];
        assign slices[i].org_x = org_x_q;
        assign slices[i].org_y = org_y_q;
        assign slices[i].pid   = pid_q;
        assign slices[i].edges = edges_q;
    end

endmodule

//--- logic/quad_merge.sv
//////////////////////////////////////////////////
// lanes packed in slice order, empty masks dropped
// done is one pulse once all slices go idle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module quad_merge (
    input  logic                                        clk,
    input  logic                                        reset,
    quad_out_if.merge                                   slices [raster_pkg::NUM_SLICES],
    output logic                                        quad_valid,
    output logic [raster_pkg::LANE_CNT_BITS-1:0]        quad_count,
    output raster_pkg::raster_quad_t [raster_pkg::OUT_LANES-1:0] quad_lanes,
    output logic                                        done
);

    logic [raster_pkg::NUM_SLICES-1:0]  s_valid;
    logic [raster_pkg::NUM_SLICES-1:0]  s_busy;
    raster_pkg::raster_quad_t           s_quad [raster_pkg::NUM_SLICES];

    raster_pkg::raster_quad_t [raster_pkg::OUT_LANES-1:0] lanes_d;
    logic [raster_pkg::LANE_CNT_BITS-1:0] count_d;

    logic seen;   // work since last done
    logic idle;

    for (genvar i = 0; i < raster_pkg::NUM_SLICES; i++) begin : g_slice
        assign s_valid[i] = slices[i].valid;
        assign s_busy[i]  = slices[i].busy;
        assign s_quad[i]  = slices[i].quad;
    end

    //////////////////////////////////////////////////
    // compaction

    always_comb begin
        lanes_d = '0;
        count_d = '0;
        for (int i = 0; i < raster_pkg::NUM_SLICES; i++) begin
            if (s_valid[i] && (s_quad[i].mask != 4'b0000)) begin
                lanes_d[count_d[raster_pkg::SLICE_BITS-1:0]] = s_quad[i];
                count_d = count_d + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            quad_valid <= 1'b0;
            quad_count <= '0;
        end else begin
            quad_valid <= (count_d != '0);
            quad_count <= count_d;
        end
    end

    always_ff @(posedge clk) begin
        quad_lanes <= lanes_d;  // unused lanes already zero
    end

    //////////////////////////////////////////////////
    // drain detect

    assign idle = ~(|s_busy) && ~(|s_valid) && ~quad_valid;
    assign done = seen && idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            seen <= 1'b0;
        end else begin
            seen <= (seen && ~done) || (|s_busy) || (|s_valid);
        end
    end

endmodule

//--- logic/tile_raster.sv
//////////////////////////////////////////////////
// no back-pressure, strobes >= 4 cycles apart
// quad k of a primitive leaves at t+3+k
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tile_raster (
    input  logic                                        clk,
    input  logic                                        reset,

    // primitive input
    input  logic                                        prim_valid,
    input  logic [raster_pkg::DIM_BITS-1:0]             prim_tile_x,
    input  logic [raster_pkg::DIM_BITS-1:0]             prim_tile_y,
    input  logic [raster_pkg::PID_BITS-1:0]             prim_pid,
    input  raster_pkg::edge_t [2:0]                     prim_edges,

    // quad output
    output logic                                        quad_valid,
    output logic [raster_pkg::LANE_CNT_BITS-1:0]        quad_count,
    output raster_pkg::raster_quad_t [raster_pkg::OUT_LANES-1:0] quad_lanes,
    output logic                                        done
);

    slice_in_if slice_in  [raster_pkg::NUM_SLICES] ();
    quad_out_if quad_out  [raster_pkg::NUM_SLICES] ();

    //////////////////////////////////////////////////
    // setup and dispatch

    edge_setup edge_setup_i (
        .clk         (clk),
        .reset       (reset),
        .prim_valid  (prim_valid),
        .prim_tile_x (prim_tile_x),
        .prim_tile_y (prim_tile_y),
        .prim_pid    (prim_pid),
        .prim_edges  (prim_edges),
        .slices      (slice_in)
    );

    //////////////////////////////////////////////////
    // slice array

    for (genvar i = 0; i < raster_pkg::NUM_SLICES; i++) begin : g_slice
        raster_slice raster_slice_i (
            .clk   (clk),
            .reset (reset),
            .in    (slice_in[i]),
            .out   (quad_out[i])
        );
    end

    //////////////////////////////////////////////////
    // output merge

    quad_merge quad_merge_i (
        .clk        (clk),
        .reset      (reset),
        .slices     (quad_out),
        .quad_valid (quad_valid),
        .quad_count (quad_count),
        .quad_lanes (quad_lanes),
        .done       (done)
    );

endmodule

//--- raster_slice/raster_slice.sv
//////////////////////////////////////////////////
// a start while walking restarts the walk
// covered when all three edges are >= 0
//////////////////////////////////////////////////

`timescale 1ns/1ps

module raster_slice (
    input  logic      clk,
    input  logic      reset,
    slice_in_if.slice in,
    quad_out_if.slice out
);

    logic                                 active;
    logic [raster_pkg::QUAD_IDX_BITS-1:0] quad_idx;

    logic [raster_pkg::DIM_BITS-1:0]      org_x;
    logic [raster_pkg::DIM_BITS-1:0]      org_y;
    logic [raster_pkg::PID_BITS-1:0]      pid;
    logic signed [raster_pkg::EDGE_BITS-1:0] step_a  [3];
    logic signed [raster_pkg::EDGE_BITS-1:0] step_b  [3];
    logic signed [raster_pkg::EDGE_BITS-1:0] row_val [3];  // at start of quad row
    logic signed [raster_pkg::EDGE_BITS-1:0] cur_val [3];  // at quad top left

    logic [raster_pkg::TILE_LOGSIZE-2:0]  qx;
    logic [raster_pkg::QUAD_IDX_BITS-raster_pkg::TILE_LOGSIZE:0] qy;
    logic signed [raster_pkg::EDGE_BITS-1:0] pix_val [4];
    logic [3:0]                           mask;

    assign qx = quad_idx[raster_pkg::TILE_LOGSIZE-2:0];
    assign qy = quad_idx[raster_pkg::QUAD_IDX_BITS-1:raster_pkg::TILE_LOGSIZE-1];

    //////////////////////////////////////////////////
    // quad walk control

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            quad_idx <= '0;
        end else if (in.start) begin
            active   <= 1'b1;
            quad_idx <= '0;
        end else if (active) begin
            quad_idx <= quad_idx + 1'b1;
            if (quad_idx == raster_pkg::QUAD_IDX_BITS'(raster_pkg::QUADS_PER_TILE - 1)) begin
                active <= 1'b0;  // last quad
            end
        end
    end

    // incremental edge stepping, two pixels per quad
    always_ff @(posedge clk) begin
        if (in.start) begin
            org_x <= in.org_x;
            org_y <= in.org_y;
            pid   <= in.pid;
            for (int e = 0; e < 3; e++) begin
                step_a[e]  <= in.edges[e].a;
                step_b[e]  <= in.edges[e].b;
                row_val[e] <= in.edges[e].c;
                cur_val[e] <= in.edges[e].c;
            end
        end else if (active) begin
            for (int e = 0; e < 3; e++) begin
                if (&qx) begin
                    row_val[e] <= row_val[e] + (step_b[e] <<< 1);
                    cur_val[e] <= row_val[e] + (step_b[e] <<< 1);
                end else begin
                    cur_val[e] <= cur_val[e] + (step_a[e] <<< 1);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // coverage test

    always_comb begin
        mask = 4'b1111;
        for (int e = 0; e < 3; e++) begin
            pix_val[0] = cur_val[e];
            pix_val[1] = cur_val[e] + step_a[e];
            pix_val[2] = cur_val[e] + step_b[e];
            pix_val[3] = cur_val[e] + step_a[e] + step_b[e];
            for (int p = 0; p < 4; p++) begin
                if (pix_val[p] < 0) begin
                    mask[p] = 1'b0;
                end
            end
        end
    end

    assign out.valid      = active;
    assign out.busy       = active;
    assign out.quad.pos_x = org_x + raster_pkg::DIM_BITS'({qx, 1'b0});
    assign out.quad.pos_y = org_y + raster_pkg::DIM_BITS'({qy, 1'b0});
    assign out.quad.mask  = mask;
    assign out.quad.pid   = pid;

endmodule

//--- tile_raster.f
common/raster_pkg.sv
common/slice_in_if.sv
common/quad_out_if.sv
logic/edge_setup.sv
raster_slice/raster_slice.sv
logic/quad_merge.sv
logic/tile_raster.sv
dv/tile_raster_tb.sv
